// File: src/ising_cfg_pkg.sv
// Sizes fixed for a 16-spin core; 10-bit fields and 16-bit energy leave headroom for all inputs

package ising_cfg_pkg;

    //////////////////////////////////////////////////
    // Problem size
    //////////////////////////////////////////////////
    localparam int NUM_SPIN   = 16;
    localparam int IDX_BIT    = $clog2(NUM_SPIN);

    // Signed coupling and bias widths
    localparam int BIT_J      = 4;
    localparam int BIT_H      = 8;

    // Worst case field is NUM_SPIN*8 + 128
    localparam int FIELD_BIT  = 10;
    localparam int ENERGY_BIT = 16;

    //////////////////////////////////////////////////
    // Data types
    //////////////////////////////////////////////////
    // Bit 1 is spin +1, bit 0 is spin -1
    typedef logic [NUM_SPIN-1:0] spin_vec_t;
    typedef logic [IDX_BIT-1:0]  spin_idx_t;

    // Coupling j at offset j*BIT_J
    typedef logic [NUM_SPIN-1:0][BIT_J-1:0] j_row_t;

    // Bias of spin i at offset i*BIT_H
    typedef logic [NUM_SPIN-1:0][BIT_H-1:0] h_vec_t;

    typedef logic signed [FIELD_BIT-1:0]  field_t;
    typedef logic signed [ENERGY_BIT-1:0] energy_t;

endpackage

// File: src/ising_ctrl_pkg.sv
// Sweep control types; a run holds at most 255 sweeps

package ising_ctrl_pkg;

    localparam int ITER_BIT = 8;

    typedef logic [ITER_BIT-1:0] iter_cnt_t;

    typedef enum logic [1:0] {
        SWP_IDLE   = 2'd0,
        SWP_ISSUE  = 2'd1,
        SWP_DRAIN  = 2'd2,
        SWP_COMMIT = 2'd3
    } sweep_state_e;

endpackage

// File: src/sweep_sequencer.sv
// Start is taken only while idle; an iteration count of zero runs a single sweep
`timescale 1ns/100ps

module sweep_sequencer (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      start_i,
    input  ising_ctrl_pkg::iter_cnt_t iter_num_i,
    output logic                      rd_en_o,
    output ising_cfg_pkg::spin_idx_t  rd_idx_o,
    output logic                      load_o,
    output logic                      commit_o,
    output logic                      idle_o
);
    import ising_cfg_pkg::*;
    import ising_ctrl_pkg::*;

    sweep_state_e state_q;
    sweep_state_e state_d;
    spin_idx_t    idx_q;
    logic         drain_q;
    iter_cnt_t    sweep_cnt_q;
    logic         done_q;
    logic         last_sweep;
    logic         last_idx;

    assign last_sweep = (iter_num_i == '0) || (sweep_cnt_q == iter_num_i - 1'b1);
    assign last_idx   = (idx_q == spin_idx_t'(NUM_SPIN - 1));

    // Hold idle low for one cycle so it rises after the final energy strobe
    assign idle_o   = (state_q == SWP_IDLE) && !done_q;
    assign load_o   = start_i && idle_o;
    assign rd_en_o  = (state_q == SWP_ISSUE);
    assign rd_idx_o = idx_q;
    assign commit_o = (state_q == SWP_COMMIT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            SWP_IDLE: begin
                if (load_o) begin
                    state_d = SWP_ISSUE;
                end
            end
            SWP_ISSUE: begin
                if (last_idx) begin
                    state_d = SWP_DRAIN;
                end
            end
            SWP_DRAIN: begin
                // Two cycles for memory and field stage
                if (drain_q) begin
                    state_d = SWP_COMMIT;
                end
            end
            SWP_COMMIT: begin
                state_d = last_sweep ? SWP_IDLE : SWP_ISSUE;
            end
            default: begin
                state_d = SWP_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= SWP_IDLE;
            idx_q       <= '0;
            drain_q     <= 1'b0;
            sweep_cnt_q <= '0;
            done_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= commit_o && last_sweep;
            drain_q <= (state_q == SWP_DRAIN) && !drain_q;
            if (rd_en_o) begin
                idx_q <= last_idx ? '0 : idx_q + 1'b1;
            end
            if (load_o) begin
                sweep_cnt_q <= '0;
            end else if (commit_o) begin
                sweep_cnt_q <= sweep_cnt_q + 1'b1;
            end
        end
    end

    // No read left in the memory or field stage at commit
    a_no_read_on_commit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        commit_o |-> !rd_en_o && !$past(rd_en_o) && !$past(rd_en_o, 2))
        else $error("commit_o with rd_en_o high or reads still in flight");

    // First commit lands after one full issue plus the two-stage pipeline
    a_first_commit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        load_o |-> ##(NUM_SPIN + 3) commit_o)
        else $error("commit_o missing NUM_SPIN+3 cycles after load_o");

endmodule

// File: src/j_weight_mem.sv
// Host writes and sweep reads must not share a cycle; read data comes one cycle later
`timescale 1ns/100ps

module j_weight_mem (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     wr_en_i,
    input  ising_cfg_pkg::spin_idx_t wr_addr_i,
    input  ising_cfg_pkg::j_row_t    wr_row_i,
    input  logic                     rd_en_i,
    input  ising_cfg_pkg::spin_idx_t rd_idx_i,
    output ising_cfg_pkg::j_row_t    row_o,
    output logic                     row_vld_o,
    output ising_cfg_pkg::spin_idx_t row_idx_o
);
    import ising_cfg_pkg::*;

    j_row_t    mem_q [NUM_SPIN];
    j_row_t    row_q;
    spin_idx_t row_idx_q;
    logic      row_vld_q;

    // One row per spin
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_row_i;
        end
        if (rd_en_i) begin
            row_q     <= mem_q[rd_idx_i];
            row_idx_q <= rd_idx_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            row_vld_q <= 1'b0;
        end else begin
            row_vld_q <= rd_en_i;
        end
    end

    assign row_o     = row_q;
    assign row_vld_o = row_vld_q;
    assign row_idx_o = row_idx_q;

    a_no_write_during_run: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(wr_en_i && rd_en_i))
        else $error("wr_en_i and rd_en_i high together");

endmodule

// File: src/local_field_calc.sv
// Field uses the spin snapshot given on spin_i; the caller keeps it fixed for the whole sweep
`timescale 1ns/100ps

module local_field_calc (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  ising_cfg_pkg::j_row_t    row_i,
    input  logic                     row_vld_i,
    input  ising_cfg_pkg::spin_idx_t row_idx_i,
    input  ising_cfg_pkg::spin_vec_t spin_i,
    input  ising_cfg_pkg::h_vec_t    bias_i,
    output ising_cfg_pkg::field_t    field_o,
    output logic                     fld_vld_o,
    output ising_cfg_pkg::spin_idx_t fld_idx_o
);
    import ising_cfg_pkg::*;

    logic signed [BIT_H-1:0] h_val;
    logic signed [BIT_J-1:0] j_val;
    field_t                  field_sum;
    field_t                  field_q;
    spin_idx_t               fld_idx_q;
    logic                    fld_vld_q;

    // Bias of this row's spin, then +J or -J per neighbour
    always_comb begin
        h_val     = bias_i[row_idx_i];
        j_val     = '0;
        field_sum = field_t'(h_val);
        for (int j = 0; j < NUM_SPIN; j++) begin
            j_val = row_i[j];
            if (spin_i[j]) begin
                field_sum = field_sum + field_t'(j_val);
            end else begin
                field_sum = field_sum - field_t'(j_val);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        field_q   <= field_sum;
        fld_idx_q <= row_idx_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fld_vld_q <= 1'b0;
        end else begin
            fld_vld_q <= row_vld_i;
        end
    end

    assign field_o   = field_q;
    assign fld_vld_o = fld_vld_q;
    assign fld_idx_o = fld_idx_q;

endmodule

// File: src/spin_update.sv
// Every spin must see exactly one valid field per sweep before commit_i
`timescale 1ns/100ps

module spin_update (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  ising_cfg_pkg::field_t    field_i,
    input  logic                     fld_vld_i,
    input  ising_cfg_pkg::spin_idx_t fld_idx_i,
    input  ising_cfg_pkg::spin_vec_t flip_mask_i,
    input  ising_cfg_pkg::spin_vec_t spin_init_i,
    input  logic                     load_i,
    input  logic                     commit_i,
    output ising_cfg_pkg::spin_vec_t spin_o,
    output ising_cfg_pkg::energy_t   energy_o,
    output logic                     energy_valid_o
);
    import ising_cfg_pkg::*;

    spin_vec_t spin_q;
    spin_vec_t shadow_q;
    energy_t   acc_q;
    energy_t   energy_q;
    logic      energy_valid_q;
    energy_t   field_ext;
    logic      new_spin;

    assign field_ext = energy_t'(field_i);

    //////////////////////////////////////////////////
    // Spin decision
    //////////////////////////////////////////////////
    // Masked spins hold, others take the field sign (zero counts as +1)
    assign new_spin = flip_mask_i[fld_idx_i] ? spin_q[fld_idx_i] : ~field_i[FIELD_BIT-1];

    always_ff @(posedge clk_i) begin
        if (fld_vld_i) begin
            shadow_q[fld_idx_i] <= new_spin;
        end
    end

    //////////////////////////////////////////////////
    // Spin register and energy
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            spin_q         <= '0;
            acc_q          <= '0;
            energy_q       <= '0;
            energy_valid_q <= 1'b0;
        end else begin
            energy_valid_q <= commit_i;
            if (load_i) begin
                spin_q <= spin_init_i;
                acc_q  <= '0;
            end else if (commit_i) begin
                spin_q   <= shadow_q;
                energy_q <= -acc_q;
                acc_q    <= '0;
            end else if (fld_vld_i) begin
                // s_i * f_i with the spin from before the sweep
                if (spin_q[fld_idx_i]) begin
                    acc_q <= acc_q + field_ext;
                end else begin
                    acc_q <= acc_q - field_ext;
                end
            end
        end
    end

    assign spin_o         = spin_q;
    assign energy_o       = energy_q;
    assign energy_valid_o = energy_valid_q;

    a_drained_before_commit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(fld_vld_i && commit_i))
        else $error("fld_vld_i high during commit_i");

endmodule

// File: src/ising_core.sv
// Bias, initial spins, mask and iteration count must stay stable from start to idle
`timescale 1ns/100ps

module ising_core (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      wr_en_i,
    input  ising_cfg_pkg::spin_idx_t  wr_addr_i,
    input  ising_cfg_pkg::j_row_t     wr_row_i,
    input  ising_cfg_pkg::h_vec_t     bias_i,
    input  ising_cfg_pkg::spin_vec_t  spin_init_i,
    input  ising_cfg_pkg::spin_vec_t  flip_mask_i,
    input  ising_ctrl_pkg::iter_cnt_t iter_num_i,
    input  logic                      start_i,
    output ising_cfg_pkg::spin_vec_t  spin_o,
    output ising_cfg_pkg::energy_t    energy_o,
    output logic                      energy_valid_o,
    output logic                      idle_o
);
    import ising_cfg_pkg::*;

    logic      rd_en;
    spin_idx_t rd_idx;
    logic      load;
    logic      commit;
    j_row_t    row;
    logic      row_vld;
    spin_idx_t row_idx;
    field_t    field;
    logic      fld_vld;
    spin_idx_t fld_idx;

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////
    sweep_sequencer u_sweep_sequencer (
        .clk_i      (clk_i      ),
        .arst_n_i   (arst_n_i   ),
        .start_i    (start_i    ),
        .iter_num_i (iter_num_i ),
        .rd_en_o    (rd_en      ),
        .rd_idx_o   (rd_idx     ),
        .load_o     (load       ),
        .commit_o   (commit     ),
        .idle_o     (idle_o     )
    );

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////
    j_weight_mem u_j_weight_mem (
        .clk_i      (clk_i      ),
        .arst_n_i   (arst_n_i   ),
        .wr_en_i    (wr_en_i    ),
        .wr_addr_i  (wr_addr_i  ),
        .wr_row_i   (wr_row_i   ),
        .rd_en_i    (rd_en      ),
        .rd_idx_i   (rd_idx     ),
        .row_o      (row        ),
        .row_vld_o  (row_vld    ),
        .row_idx_o  (row_idx    )
    );

    // Committed spins are the snapshot
    local_field_calc u_local_field_calc (
        .clk_i      (clk_i      ),
        .arst_n_i   (arst_n_i   ),
        .row_i      (row        ),
        .row_vld_i  (row_vld    ),
        .row_idx_i  (row_idx    ),
        .spin_i     (spin_o     ),
        .bias_i     (bias_i     ),
        .field_o    (field      ),
        .fld_vld_o  (fld_vld    ),
        .fld_idx_o  (fld_idx    )
    );

    spin_update u_spin_update (
        .clk_i          (clk_i          ),
        .arst_n_i       (arst_n_i       ),
        .field_i        (field          ),
        .fld_vld_i      (fld_vld        ),
        .fld_idx_i      (fld_idx        ),
        .flip_mask_i    (flip_mask_i    ),
        .spin_init_i    (spin_init_i    ),
        .load_i         (load           ),
        .commit_i       (commit         ),
        .spin_o         (spin_o         ),
        .energy_o       (energy_o       ),
        .energy_valid_o (energy_valid_o )
    );

endmodule

// File: tests/tb_ising_core.sv
// Runs from the project root so that tests/ising_stim.txt resolves; weight rows start cleared
`timescale 1ns/100ps

module tb_ising_core;
    import ising_cfg_pkg::*;
    import ising_ctrl_pkg::*;

    localparam int RUN_TIMEOUT = 2000;

    logic      clk_i;
    logic      arst_n_i;
    logic      wr_en_i;
    spin_idx_t wr_addr_i;
    j_row_t    wr_row_i;
    h_vec_t    bias_i;
    spin_vec_t spin_init_i;
    spin_vec_t flip_mask_i;
    iter_cnt_t iter_num_i;
    logic      start_i;
    spin_vec_t spin_o;
    energy_t   energy_o;
    logic      energy_valid_o;
    logic      idle_o;

    int err_count;
    int test_count;
    int fail_count;
    bit aborted;

    ising_core ising_core_i (
        .clk_i          (clk_i          ),
        .arst_n_i       (arst_n_i       ),
        .wr_en_i        (wr_en_i        ),
        .wr_addr_i      (wr_addr_i      ),
        .wr_row_i       (wr_row_i       ),
        .bias_i         (bias_i         ),
        .spin_init_i    (spin_init_i    ),
        .flip_mask_i    (flip_mask_i    ),
        .iter_num_i     (iter_num_i     ),
        .start_i        (start_i        ),
        .spin_o         (spin_o         ),
        .energy_o       (energy_o       ),
        .energy_valid_o (energy_valid_o ),
        .idle_o         (idle_o         )
    );

    always #5 clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic string test_name(input int num);
        case (num)
            1: return "reset state";
            2: return "bias only";
            3: return "ferromagnetic couplings";
            4: return "flip mask";
            5: return "several sweeps";
            default: return "unnamed";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input int num, input int err_before);
        test_count++;
        if (err_count == err_before) begin
            $display("test %0d (%s): PASS", num, test_name(num));
        end else begin
            fail_count++;
            $display("test %0d (%s): FAIL", num, test_name(num));
        end
    endtask

    task automatic write_row(input spin_idx_t addr, input j_row_t row);
        @(negedge clk_i);
        wr_en_i   = 1'b1;
        wr_addr_i = addr;
        wr_row_i  = row;
        @(negedge clk_i);
        wr_en_i   = 1'b0;
    endtask

    task automatic run_test(input int num, input h_vec_t bias, input spin_vec_t init,
                            input spin_vec_t mask, input iter_cnt_t iter,
                            input spin_vec_t exp_spin, input energy_t exp_energy);
        int pulses;
        int cycles;
        int err_before;
        int exp_pulses;
        err_before = err_count;
        // A sweep count of zero still runs one sweep
        exp_pulses = (iter == '0) ? 1 : int'(iter);
        pulses     = 0;
        cycles     = 0;
        @(negedge clk_i);
        bias_i      = bias;
        spin_init_i = init;
        flip_mask_i = mask;
        iter_num_i  = iter;
        start_i     = 1'b1;
        @(negedge clk_i);
        start_i     = 1'b0;
        assert (idle_o === 1'b0) else begin
            $display("Test %0d did not start, idle_o stayed high after start_i", num);
            err_count++;
        end
        // Count energy strobes until the core is idle again
        while (idle_o !== 1'b1 && cycles < RUN_TIMEOUT) begin
            if (energy_valid_o === 1'b1) begin
                pulses++;
            end
            @(negedge clk_i);
            cycles++;
        end
        if (cycles >= RUN_TIMEOUT) begin
            $display("Test %0d timed out, idle_o never rose after start_i", num);
            err_count++;
            aborted = 1'b1;
        end
        check_value("energy_valid_o pulses", pulses[15:0], exp_pulses[15:0]);
        check_value("spin_o", spin_o, exp_spin);
        check_value("energy_o", energy_o, exp_energy);
        report_test(num, err_before);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int        fd;
        int        n;
        int        num;
        int        iter_val;
        int        err_before;
        string     line;
        spin_idx_t addr_val;
        j_row_t    row_val;
        h_vec_t    bias_val;
        spin_vec_t init_val;
        spin_vec_t mask_val;
        spin_vec_t exp_spin;
        energy_t   exp_energy;

        clk_i       = 1'b0;
        arst_n_i    = 1'b0;
        wr_en_i     = 1'b0;
        wr_addr_i   = '0;
        wr_row_i    = '0;
        bias_i      = '0;
        spin_init_i = '0;
        flip_mask_i = '0;
        iter_num_i  = '0;
        start_i     = 1'b0;
        err_count   = 0;
        test_count  = 0;
        fail_count  = 0;
        aborted     = 1'b0;

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        err_before = err_count;
        check_value("idle_o", idle_o, 16'h1);
        check_value("energy_valid_o", energy_valid_o, 16'h0);
        check_value("spin_o", spin_o, 16'h0);
        check_value("energy_o", energy_o, 16'h0);
        report_test(1, err_before);

        // Start from all-zero couplings
        for (int a = 0; a < NUM_SPIN; a++) begin
            write_row(spin_idx_t'(a), '0);
        end

        fd = $fopen("tests/ising_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open stimulus file tests/ising_stim.txt");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) == "W") begin
                n = $sscanf(line, "W %h %h", addr_val, row_val);
                assert (n == 2) else begin
                    $display("Malformed weight line in stimulus file: %s", line);
                    err_count++;
                end
                write_row(addr_val, row_val);
            end else if (n > 0 && line.getc(0) == "T") begin
                n = $sscanf(line, "T %d %h %h %h %d %h %h", num, bias_val, init_val,
                            mask_val, iter_val, exp_spin, exp_energy);
                assert (n == 7) else begin
                    $display("Malformed test line in stimulus file: %s", line);
                    err_count++;
                end
                run_test(num, bias_val, init_val, mask_val, iter_cnt_t'(iter_val),
                         exp_spin, exp_energy);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        assert (test_count > 1) else begin
            $display("No tests were read from the stimulus file");
            err_count++;
        end

        $display("tests run: %0d, passed: %0d, failed: %0d",
                 test_count, test_count - fail_count, fail_count);
        if (err_count == 0 && !aborted) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: tests/ising_stim.txt
# W <row address hex> <coupling row hex, coupling j is hex digit j from the right>
# T <test> <bias hex> <initial spins hex> <mask hex> <sweeps dec> <spins hex> <energy hex>
T 2 8010FD05 00F3 0000 1 FFF5 FF8E
W 0 1110
W 1 1101
W 2 1011
W 3 0111
T 3 0 0009 0000 1 FFF6 0004
T 4 0 0009 8003 1 7FF5 0004
T 5 2 0009 0000 3 FFFF FFF2

// File: flist.f
src/ising_cfg_pkg.sv
src/ising_ctrl_pkg.sv
src/sweep_sequencer.sv
src/j_weight_mem.sv
src/local_field_calc.sv
src/spin_update.sv
src/ising_core.sv
tests/tb_ising_core.sv

// File: Bender.yml
package:
  name: ising_core

sources:
  - src/ising_cfg_pkg.sv
  - src/ising_ctrl_pkg.sv
  - src/sweep_sequencer.sv
  - src/j_weight_mem.sv
  - src/local_field_calc.sv
  - src/spin_update.sv
  - src/ising_core.sv
  - target: test
    files:
      - tests/tb_ising_core.sv
